//--- hw/card_config.svh
/*
 * Card glue configuration constants
 * Source count, audio alignment shifts and Apple bus output enables
 */

`ifndef CARD_CONFIG_SVH
`define CARD_CONFIG_SVH

// Responding peripherals on the card
`define CARD_NUM_SOURCES 5

// Audio alignment into the 16-bit mix
`define CARD_PERIPH_AUDIO_SHIFT 3
`define CARD_SPEAKER_SHIFT 12

// Clear these to keep the card off the Apple bus
`define CARD_BUS_DATA_OUT_ENABLE 1
`define CARD_IRQ_OUT_ENABLE 1

`endif

//--- hw/card_pkg.sv
/*
 * Card glue shared types
 * Bus bytes, responding source codes, audio samples and pixels
 */

`include "card_config.svh"

package card_pkg;

    typedef logic [7:0] a2_byte_t;  // Apple bus data

    // Responding card, NONE when nobody answers the read
    typedef enum logic [2:0] {
        SRC_NONE    = 3'd0,
        SRC_SSC     = 3'd1,  // Super serial
        SRC_SSP     = 3'd2,  // Sprite
        SRC_MB      = 3'd3,  // Mockingboard
        SRC_DISKII  = 3'd4,
        SRC_CARDROM = 3'd5
    } card_src_e;

    // Bit 0 has highest priority
    typedef logic [`CARD_NUM_SOURCES-1:0] rd_vec_t;

    typedef logic [9:0] periph_audio_t;          // Unsigned 10-bit
    typedef logic signed [15:0] audio_sample_t;  // Signed, mix and Ensoniq

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

//--- hw/slot_resp_if.sv
/*
 * Slot response link
 * Carries the winning card response from decode to the bus drive stage
 */

interface slot_resp_if;

    logic                 valid;  // Some strobe won
    card_pkg::card_src_e  src;
    card_pkg::a2_byte_t   data;
    logic                 irq_n;  // Merged, active low

    modport producer (
        output valid, src, data, irq_n
    );

    modport consumer (
        input valid, src, data, irq_n
    );

endinterface

//--- hw/slot_resp_decode.sv
/*
 * Slot response decode
 * Fixed priority pick of the card answering a bus read, plus the
 * interrupt merge, registered into the response link
 */

`include "card_config.svh"

module slot_resp_decode (
    input  logic                 clk_logic_w,
    input  logic                 reset_i,
    input  card_pkg::rd_vec_t    rd_en_i,
    input  card_pkg::a2_byte_t   ssc_data_i,
    input  card_pkg::a2_byte_t   ssp_data_i,
    input  card_pkg::a2_byte_t   mb_data_i,
    input  card_pkg::a2_byte_t   diskii_data_i,
    input  card_pkg::a2_byte_t   cardrom_data_i,
    input  card_pkg::a2_byte_t   bus_data_i,
    input  logic                 mb_irq_n_i,
    input  logic                 vdp_irq_n_i,
    input  logic                 ssc_irq_n_i,
    slot_resp_if.producer        resp_o
);

    card_pkg::a2_byte_t  src_data_w [`CARD_NUM_SOURCES];
    card_pkg::a2_byte_t  sel_data_w;
    card_pkg::card_src_e sel_src_w;

    // Same order as the strobe vector
    assign src_data_w[0] = ssc_data_i;
    assign src_data_w[1] = ssp_data_i;
    assign src_data_w[2] = mb_data_i;
    assign src_data_w[3] = diskii_data_i;
    assign src_data_w[4] = cardrom_data_i;

    // Walk down from the lowest priority so bit 0 ends up the winner
    always_comb begin
        sel_src_w  = card_pkg::SRC_NONE;
        sel_data_w = bus_data_i;  // Nobody answers, bus byte passes
        for (int i = `CARD_NUM_SOURCES - 1; i >= 0; i--) begin
            if (rd_en_i[i]) begin
                sel_src_w  = card_pkg::card_src_e'(3'(i + 1));
                sel_data_w = src_data_w[i];
            end
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            resp_o.valid <= 1'b0;
            resp_o.src   <= card_pkg::SRC_NONE;
            resp_o.irq_n <= 1'b1;
        end else begin
            resp_o.valid <= |rd_en_i;
            resp_o.src   <= sel_src_w;
            resp_o.irq_n <= mb_irq_n_i & vdp_irq_n_i & ssc_irq_n_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        resp_o.data <= sel_data_w;
    end

endmodule

//--- hw/bus_drive.sv
/*
 * Apple bus drive stage
 * Registers the outgoing byte, its output enable during phi0 and the
 * card interrupt line
 */

`include "card_config.svh"

module bus_drive (
    input  logic                 clk_logic_w,
    input  logic                 reset_i,
    input  logic                 phi0_i,
    slot_resp_if.consumer        resp_i,
    output card_pkg::a2_byte_t   bus_data_o,
    output logic                 bus_data_oe_o,
    output logic                 irq_n_o
);

    localparam bit DATA_OUT_EN = (`CARD_BUS_DATA_OUT_ENABLE != 0);
    localparam bit IRQ_OUT_EN  = (`CARD_IRQ_OUT_ENABLE != 0);

    logic drive_w;
    logic irq_n_w;

    // Only a real card answer may drive, and only while phi0 is high
    assign drive_w = DATA_OUT_EN && phi0_i && resp_i.valid &&
                     (resp_i.src != card_pkg::SRC_NONE);

    assign irq_n_w = IRQ_OUT_EN ? resp_i.irq_n : 1'b1;  // Held off when disabled

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            bus_data_oe_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            bus_data_oe_o <= drive_w;
            irq_n_o       <= irq_n_w;
        end
    end

    // Byte follows every cycle, the enable decides if it reaches the bus
    always_ff @(posedge clk_logic_w) begin
        bus_data_o <= resp_i.data;
    end

endmodule

//--- hw/audio_mixer.sv
/*
 * Audio mixer
 * Aligns speaker, sprite and Mockingboard audio to the Ensoniq scale and
 * sums them into one registered stereo pair
 */

`include "card_config.svh"

module audio_mixer (
    input  logic                     clk_logic_w,
    input  logic                     reset_i,
    input  logic                     speaker_i,
    input  card_pkg::periph_audio_t  ssp_audio_i,
    input  card_pkg::periph_audio_t  mb_audio_l_i,
    input  card_pkg::periph_audio_t  mb_audio_r_i,
    input  card_pkg::audio_sample_t  sg_audio_l_i,
    input  card_pkg::audio_sample_t  sg_audio_r_i,
    output card_pkg::audio_sample_t  audio_l_o,
    output card_pkg::audio_sample_t  audio_r_o
);

    logic [15:0] speaker_ext_w;
    logic [15:0] ssp_ext_w;

    // One channel's sum, wraps at 16 bits
    function automatic card_pkg::audio_sample_t mix_channel(
        input card_pkg::audio_sample_t sg,
        input card_pkg::periph_audio_t mb,
        input logic [15:0] ssp_ext,
        input logic [15:0] spk_ext
    );
        logic [15:0] mb_ext;
        logic [15:0] sum;
        mb_ext = 16'(mb) << `CARD_PERIPH_AUDIO_SHIFT;
        sum = 16'(sg) + ssp_ext + mb_ext + spk_ext;
        return card_pkg::audio_sample_t'(sum);
    endfunction

    // Speaker toggle is a big step, like the real click
    assign speaker_ext_w = 16'(speaker_i) << `CARD_SPEAKER_SHIFT;
    assign ssp_ext_w     = 16'(ssp_audio_i) << `CARD_PERIPH_AUDIO_SHIFT;  // Both sides

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_channel(sg_audio_l_i, mb_audio_l_i, ssp_ext_w, speaker_ext_w);
            audio_r_o <= mix_channel(sg_audio_r_i, mb_audio_r_i, ssp_ext_w, speaker_ext_w);
        end
    end

endmodule

//--- hw/video_post.sv
/*
 * Video post-processing
 * Scanline effect, halves each colour on odd lines when enabled
 */

module video_post (
    input  logic              clk_logic_w,
    input  logic              reset_i,
    input  logic              scanlines_i,
    input  logic [9:0]        screen_y_i,
    input  card_pkg::rgb_t    pixel_i,
    output card_pkg::rgb_t    pixel_o
);

    logic           dim_w;
    card_pkg::rgb_t pixel_w;

    assign dim_w = scanlines_i && screen_y_i[0];  // Odd line

    always_comb begin
        pixel_w = pixel_i;
        if (dim_w) begin
            pixel_w.r = {1'b0, pixel_i.r[7:1]};
            pixel_w.g = {1'b0, pixel_i.g[7:1]};
            pixel_w.b = {1'b0, pixel_i.b[7:1]};
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            pixel_o <= '0;  // Black
        end else begin
            pixel_o <= pixel_w;
        end
    end

endmodule

//--- hw/card_glue_top.sv
/*
 * Apple II card glue top level
 * Bus response selection and drive, audio mix and scanline effect
 */

module card_glue_top (
    input  logic                     clk_logic_w,
    input  logic                     reset_i,
    input  logic                     phi0_i,

    // Peripheral read strobes and their bytes
    input  card_pkg::rd_vec_t        rd_en_i,
    input  card_pkg::a2_byte_t       ssc_data_i,
    input  card_pkg::a2_byte_t       ssp_data_i,
    input  card_pkg::a2_byte_t       mb_data_i,
    input  card_pkg::a2_byte_t       diskii_data_i,
    input  card_pkg::a2_byte_t       cardrom_data_i,
    input  card_pkg::a2_byte_t       bus_data_i,

    // Interrupts, active low
    input  logic                     mb_irq_n_i,
    input  logic                     vdp_irq_n_i,
    input  logic                     ssc_irq_n_i,

    // Audio sources
    input  logic                     speaker_i,
    input  card_pkg::periph_audio_t  ssp_audio_i,
    input  card_pkg::periph_audio_t  mb_audio_l_i,
    input  card_pkg::periph_audio_t  mb_audio_r_i,
    input  card_pkg::audio_sample_t  sg_audio_l_i,
    input  card_pkg::audio_sample_t  sg_audio_r_i,

    // Video
    input  logic                     scanlines_i,
    input  logic [9:0]               screen_y_i,
    input  card_pkg::rgb_t           pixel_i,

    output card_pkg::a2_byte_t       bus_data_o,
    output logic                     bus_data_oe_o,
    output logic                     irq_n_o,
    output card_pkg::audio_sample_t  audio_l_o,
    output card_pkg::audio_sample_t  audio_r_o,
    output card_pkg::rgb_t           pixel_o
);

    slot_resp_if resp_if ();

    slot_resp_decode decode0 (
        .clk_logic_w    (clk_logic_w),
        .reset_i        (reset_i),
        .rd_en_i        (rd_en_i),
        .ssc_data_i     (ssc_data_i),
        .ssp_data_i     (ssp_data_i),
        .mb_data_i      (mb_data_i),
        .diskii_data_i  (diskii_data_i),
        .cardrom_data_i (cardrom_data_i),
        .bus_data_i     (bus_data_i),
        .mb_irq_n_i     (mb_irq_n_i),
        .vdp_irq_n_i    (vdp_irq_n_i),
        .ssc_irq_n_i    (ssc_irq_n_i),
        .resp_o         (resp_if)
    );

    bus_drive drive0 (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (reset_i),
        .phi0_i        (phi0_i),
        .resp_i        (resp_if),
        .bus_data_o    (bus_data_o),
        .bus_data_oe_o (bus_data_oe_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer mixer0 (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .speaker_i    (speaker_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .sg_audio_l_i (sg_audio_l_i),
        .sg_audio_r_i (sg_audio_r_i),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o)
    );

    video_post video0 (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .scanlines_i (scanlines_i),
        .screen_y_i  (screen_y_i),
        .pixel_i     (pixel_i),
        .pixel_o     (pixel_o)
    );

endmodule

//--- verification/card_glue_props.sv
/*
 * Bus drive properties
 * Reset state and output enable rules of the Apple bus drive stage
 */

module card_glue_props (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic phi0_i,
    input  logic resp_valid_i,
    input  logic bus_oe_i,
    input  logic irq_n_i
);

    // Drive only when phi0 was high at the capturing edge
    oe_needs_phi0: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        bus_oe_i |-> $past(phi0_i))
        else $error("Bus output enable high although phi0 was low");

    // First cycle out of reset
    reset_outputs_idle: assert property (@(posedge clk_logic_w)
        $fell(reset_i) |-> (!bus_oe_i && irq_n_i))
        else $error("Bus enable or interrupt active right after reset");

    oe_needs_valid: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        bus_oe_i |-> $past(resp_valid_i))
        else $error("Bus output enable high without a valid card response");

endmodule

bind bus_drive card_glue_props props0 (
    .clk_logic_w  (clk_logic_w),
    .reset_i      (reset_i),
    .phi0_i       (phi0_i),
    .resp_valid_i (resp_i.valid),
    .bus_oe_i     (bus_data_oe_o),
    .irq_n_i      (irq_n_o)
);

//--- verification/card_glue_tb.sv
/*
 * Card glue testbench
 * Drives strobes, interrupts, audio and pixels into the top level and
 * checks every output against reference models after its latency
 */

module card_glue_tb;

    localparam logic [31:0] RNG_SEED = 32'h5684_e60a;
    localparam int N_RESET = 3;
    localparam int N_PRIO  = 32;  // Every strobe pattern
    localparam int N_PHI0  = 150;
    localparam int N_IRQ   = 64;
    localparam int N_AUDIO = 150;
    localparam int N_PIXEL = 150;
    localparam int N_DRAIN = 4;
    localparam int TIMEOUT_CYCLES = 2 * N_RESET + N_PRIO + N_PHI0 + N_IRQ + N_AUDIO
                                    + N_PIXEL + N_DRAIN + 50;

    logic                    clk_logic_w;
    logic                    reset_i;
    logic                    phi0_i;
    card_pkg::rd_vec_t       rd_en_i;
    card_pkg::a2_byte_t      ssc_data_i, ssp_data_i, mb_data_i;
    card_pkg::a2_byte_t      diskii_data_i, cardrom_data_i, bus_data_i;
    logic                    mb_irq_n_i, vdp_irq_n_i, ssc_irq_n_i;
    logic                    speaker_i;
    card_pkg::periph_audio_t ssp_audio_i, mb_audio_l_i, mb_audio_r_i;
    card_pkg::audio_sample_t sg_audio_l_i, sg_audio_r_i;
    logic                    scanlines_i;
    logic [9:0]              screen_y_i;
    card_pkg::rgb_t          pixel_i;
    card_pkg::a2_byte_t      bus_data_o;
    logic                    bus_data_oe_o;
    logic                    irq_n_o;
    card_pkg::audio_sample_t audio_l_o, audio_r_o;
    card_pkg::rgb_t          pixel_o;
    string                   test_name;
    int                      cycle_count = 0;

    card_glue_top dut0 (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #5 clk_logic_w = ~clk_logic_w;
    end

    // Lowest numbered strobe wins, nobody answering passes the bus byte
    function automatic card_pkg::a2_byte_t ref_bus_byte(input card_pkg::rd_vec_t rd,
        input card_pkg::a2_byte_t ssc, input card_pkg::a2_byte_t ssp,
        input card_pkg::a2_byte_t mb, input card_pkg::a2_byte_t diskii,
        input card_pkg::a2_byte_t cardrom, input card_pkg::a2_byte_t bus);
        if (rd[0]) return ssc;
        else if (rd[1]) return ssp;
        else if (rd[2]) return mb;
        else if (rd[3]) return diskii;
        else if (rd[4]) return cardrom;
        else return bus;
    endfunction

    function automatic logic ref_oe(input card_pkg::rd_vec_t rd, input logic phi0_next);
        return (rd != '0) && phi0_next;
    endfunction

    function automatic logic ref_irq(input logic a, input logic b, input logic c);
        return a & b & c;
    endfunction

    function automatic card_pkg::audio_sample_t ref_audio(input card_pkg::audio_sample_t sg,
        input card_pkg::periph_audio_t ssp, input card_pkg::periph_audio_t mb,
        input logic spk);
        logic [15:0] sum;
        // Peripherals times 8, speaker at 4096, wraps at 16 bits
        sum = sg + {3'b000, ssp, 3'b000} + {3'b000, mb, 3'b000} + {3'b000, spk, 12'h000};
        return sum;
    endfunction

    function automatic card_pkg::rgb_t ref_pixel(input card_pkg::rgb_t p, input logic scan,
        input logic [9:0] y);
        card_pkg::rgb_t q;
        q = p;
        if (scan && y[0]) begin
            q.r = p.r >> 1;
            q.g = p.g >> 1;
            q.b = p.b >> 1;
        end
        return q;
    endfunction

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "Output mismatch, run stopped");
    endtask

    task automatic check_byte(input string name, input card_pkg::a2_byte_t expected,
        input card_pkg::a2_byte_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_audio(input string name, input card_pkg::audio_sample_t expected,
        input card_pkg::audio_sample_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_pixel(input string name, input card_pkg::rgb_t expected,
        input card_pkg::rgb_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_logic_w);
        #1;
    endtask

    task automatic drive_idle();
        rd_en_i = '0;
        {ssc_data_i, ssp_data_i, mb_data_i} = '0;
        {diskii_data_i, cardrom_data_i, bus_data_i} = '0;
        {mb_irq_n_i, vdp_irq_n_i, ssc_irq_n_i} = 3'b111;
        speaker_i = 1'b0;
        {ssp_audio_i, mb_audio_l_i, mb_audio_r_i} = '0;
        {sg_audio_l_i, sg_audio_r_i} = '0;
        scanlines_i = 1'b0;
        screen_y_i = '0;
        pixel_i = '0;
    endtask

    // Fresh random bytes on every source and the fallback bus
    task automatic drive_bus(input card_pkg::rd_vec_t rd, input logic phi0);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = $urandom;
        w1 = $urandom;
        rd_en_i        = rd;
        phi0_i         = phi0;
        ssc_data_i     = w0[7:0];
        ssp_data_i     = w0[15:8];
        mb_data_i      = w0[23:16];
        diskii_data_i  = w0[31:24];
        cardrom_data_i = w1[7:0];
        bus_data_i     = w1[15:8];
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        logic [31:0] rnd2;
        rnd = $urandom(RNG_SEED);
        reset_i = 1'b1;
        phi0_i = 1'b0;
        test_name = "reset";
        drive_idle();
        repeat (N_RESET) @(posedge clk_logic_w);
        #1;
        reset_i = 1'b0;
        test_name = "priority";
        for (int p = 0; p < N_PRIO; p++) begin
            drive_bus(p[4:0], 1'b1);
            next_cycle();
        end
        test_name = "phi0";
        for (int i = 0; i < N_PHI0; i++) begin
            rnd = $urandom;
            drive_bus(rnd[4:0], rnd[5]);
            next_cycle();
        end
        test_name = "irq";
        for (int i = 0; i < N_IRQ; i++) begin
            rnd = $urandom;
            drive_bus(rnd[4:0], rnd[5]);
            {mb_irq_n_i, vdp_irq_n_i, ssc_irq_n_i} = rnd[10:8];
            next_cycle();
        end
        test_name = "audio";
        for (int i = 0; i < N_AUDIO; i++) begin
            rnd = $urandom;
            rnd2 = $urandom;
            sg_audio_l_i = rnd[15:0];  // Full range, so sums wrap often
            sg_audio_r_i = rnd[31:16];
            ssp_audio_i  = rnd2[9:0];
            mb_audio_l_i = rnd2[19:10];
            mb_audio_r_i = rnd2[29:20];
            speaker_i    = rnd2[30];
            next_cycle();
        end
        test_name = "scanlines";
        for (int i = 0; i < N_PIXEL; i++) begin
            rnd = $urandom;
            rnd2 = $urandom;
            pixel_i     = rnd[23:0];
            scanlines_i = rnd[24];
            screen_y_i  = rnd2[9:0];
            next_cycle();
        end
        // Busy inputs while reset is applied again
        test_name = "reset_again";
        reset_i = 1'b1;
        for (int i = 0; i < N_RESET; i++) begin
            rnd = $urandom;
            drive_bus(rnd[4:0], 1'b1);
            next_cycle();
        end
        reset_i = 1'b0;
        test_name = "drain";
        drive_idle();
        repeat (N_DRAIN) next_cycle();
        $display("Simulation PASSED");
        $finish;
    end

    // Capture at the edge, compare at the falling edge
    initial begin : compare_outputs
        card_pkg::a2_byte_t      byte_prev;
        card_pkg::a2_byte_t      exp_byte;
        card_pkg::rd_vec_t       rd_prev;
        card_pkg::audio_sample_t exp_l;
        card_pkg::audio_sample_t exp_r;
        card_pkg::rgb_t          exp_pix;
        logic                    irq_prev;
        logic                    reset_prev;
        logic                    exp_oe;
        logic                    exp_irq;
        string                   name_prev;
        string                   name_bus;
        string                   name_now;
        int                      seen;
        reset_prev = 1'b1;
        irq_prev = 1'b1;
        rd_prev = '0;
        byte_prev = '0;
        name_prev = "reset";
        seen = 0;
        forever begin
            @(posedge clk_logic_w);
            name_now = test_name;
            exp_l = reset_i ? '0 : ref_audio(sg_audio_l_i, ssp_audio_i, mb_audio_l_i,
                                             speaker_i);
            exp_r = reset_i ? '0 : ref_audio(sg_audio_r_i, ssp_audio_i, mb_audio_r_i,
                                             speaker_i);
            exp_pix = reset_i ? '0 : ref_pixel(pixel_i, scanlines_i, screen_y_i);
            // Bus path has two stages, phi0 comes from the second
            if (reset_i || reset_prev) begin
                exp_oe = 1'b0;
                exp_irq = 1'b1;
            end else begin
                exp_oe = ref_oe(rd_prev, phi0_i);
                exp_irq = irq_prev;
            end
            exp_byte = byte_prev;
            name_bus = name_prev;
            rd_prev = rd_en_i;
            irq_prev = ref_irq(mb_irq_n_i, vdp_irq_n_i, ssc_irq_n_i);
            byte_prev = ref_bus_byte(rd_en_i, ssc_data_i, ssp_data_i, mb_data_i,
                                     diskii_data_i, cardrom_data_i, bus_data_i);
            reset_prev = reset_i;
            name_prev = name_now;
            seen++;
            @(negedge clk_logic_w);
            check_audio({name_now, " audio_l"}, exp_l, audio_l_o);
            check_audio({name_now, " audio_r"}, exp_r, audio_r_o);
            check_pixel({name_now, " pixel"}, exp_pix, pixel_o);
            check_bit({name_bus, " bus_data_oe"}, exp_oe, bus_data_oe_o);
            check_bit({name_bus, " irq_n"}, exp_irq, irq_n_o);
            if (seen >= 2) begin
                check_byte({name_bus, " bus_data"}, exp_byte, bus_data_o);
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_logic_w);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped by the cycle limit");
    end

endmodule

//--- list.f
+incdir+hw
hw/card_pkg.sv
hw/slot_resp_if.sv
hw/slot_resp_decode.sv
hw/bus_drive.sv
hw/audio_mixer.sv
hw/video_post.sv
hw/card_glue_top.sv
verification/card_glue_props.sv
verification/card_glue_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the card glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module card_glue_tb \
    -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vcard_glue_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
